/* design/wbmem_pkg.sv */
////////////////////
// widths, depths, enums, message structs and the data replication helper
////////////////////
`default_nettype none

package wbmem_pkg;

  localparam int data_width_lp        = 64;
  localparam int sel_width_lp         = 8;
  localparam int paddr_width_lp       = 20;
  localparam int wb_addr_width_lp     = 17;
  // byte offset within a dword
  localparam int byte_offset_width_lp = paddr_width_lp - wb_addr_width_lp;
  localparam int sp_index_width_lp    = 8;
  localparam int fwd_fifo_depth_lp    = 2;
  localparam int fwd_fifo_ptr_width_lp = $clog2(fwd_fifo_depth_lp);
  localparam int fwd_fifo_cnt_width_lp = $clog2(fwd_fifo_depth_lp + 1);

  typedef enum logic [1:0] {
    size_1 = 2'b00,
    size_2 = 2'b01,
    size_4 = 2'b10,
    size_8 = 2'b11
  } msg_size_e;

  typedef enum logic {
    uc_rd = 1'b0,
    uc_wr = 1'b1
  } msg_type_e;

  // bridge FSM
  typedef enum logic [1:0] {
    st_reset     = 2'b00,
    st_ready     = 2'b01,
    st_wait_read = 2'b10
  } bridge_state_e;

  typedef struct packed {
    msg_type_e                 msg_type;
    msg_size_e                 size;
    logic [paddr_width_lp-1:0] addr;
  } mem_hdr_s;

  // shared by command and response channels
  typedef struct packed {
    mem_hdr_s                 hdr;
    logic [data_width_lp-1:0] data;
  } mem_msg_s;

  // narrow data is repeated over the whole bus
  function automatic logic [data_width_lp-1:0] replicate_low(
    input logic [data_width_lp-1:0] data,
    input msg_size_e                size
  );
    logic [data_width_lp-1:0] result;
    case (size)
      size_1:  result = {8{data[7:0]}};
      size_2:  result = {4{data[15:0]}};
      size_4:  result = {2{data[31:0]}};
      default: result = data;
    endcase
    return result;
  endfunction

endpackage

`default_nettype wire

/* design/wb_client_bridge.sv */
////////////////////
// Wishbone client to memory command bridge
////////////////////
`timescale 1ns/1ps
`default_nettype none

module wb_client_bridge (
  input  wire logic                                  clk_i,
  input  wire logic                                  reset_i,

  // Wishbone client side
  input  wire logic [wbmem_pkg::wb_addr_width_lp-1:0] adr_i,
  input  wire logic [wbmem_pkg::data_width_lp-1:0]    dat_i,
  input  wire logic                                  cyc_i,
  input  wire logic                                  stb_i,
  input  wire logic [wbmem_pkg::sel_width_lp-1:0]     sel_i,
  input  wire logic                                  we_i,
  output logic [wbmem_pkg::data_width_lp-1:0]         dat_o,
  output logic                                       ack_o,

  // command channel
  output wbmem_pkg::mem_msg_s                        fwd_msg_o,
  output logic                                       fwd_v_o,
  input  wire logic                                  fwd_ready_and_i,

  // response channel is always taken
  input  wire wbmem_pkg::mem_msg_s                   rev_msg_i,
  input  wire logic                                  rev_v_i
);

  import wbmem_pkg::*;

  bridge_state_e state_r;
  bridge_state_e state_n;
  msg_size_e     msg_size;
  logic          fwd_handshake;
  logic          rd_resp;

  // size decode from byte selects
  always_comb begin
    case (sel_i)
      8'h01:   msg_size = size_1;
      8'h03:   msg_size = size_2;
      8'h0F:   msg_size = size_4;
      default: msg_size = size_8;
    endcase
  end

  // command fields with the word address padded to a byte address
  always_comb begin
    fwd_msg_o.hdr.msg_type = we_i ? uc_wr : uc_rd;
    fwd_msg_o.hdr.size     = msg_size;
    fwd_msg_o.hdr.addr     = {adr_i, {byte_offset_width_lp{1'b0}}};
    fwd_msg_o.data         = replicate_low(dat_i, msg_size);
  end

  // write responses are dropped here
  assign rd_resp = rev_v_i & (rev_msg_i.hdr.msg_type == uc_rd);
  assign dat_o   = rev_msg_i.data;

  assign fwd_handshake = fwd_v_o & fwd_ready_and_i;

  always_comb begin
    state_n = state_r;
    fwd_v_o = 1'b0;
    ack_o   = 1'b0;

    case (state_r)
      st_reset: begin
        state_n = st_ready;
      end

      st_ready: begin
        fwd_v_o = cyc_i & stb_i;
        // writes ack on handshake and reads only when answered at once
        ack_o   = fwd_handshake & (we_i | rd_resp);
        if (fwd_handshake & ~(we_i | rd_resp)) begin
          state_n = st_wait_read;
        end
      end

      st_wait_read: begin
        ack_o = rd_resp;
        if (rd_resp) begin
          state_n = st_ready;
        end
      end

      default: begin
        state_n = st_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= st_reset;
    end else begin
      state_r <= state_n;
    end
  end

endmodule

`default_nettype wire

/* design/mem_fwd_fifo.sv */
////////////////////
// two-entry command FIFO
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mem_fwd_fifo (
  input  wire logic          clk_i,
  input  wire logic          reset_i,

  input  wire wbmem_pkg::mem_msg_s data_i,
  input  wire logic          v_i,
  output logic               ready_and_o,

  output wbmem_pkg::mem_msg_s data_o,
  output logic               v_o,
  input  wire logic          yumi_i
);

  import wbmem_pkg::*;

  mem_msg_s                         entries_r [fwd_fifo_depth_lp];
  logic [fwd_fifo_ptr_width_lp-1:0] wptr_r;
  logic [fwd_fifo_ptr_width_lp-1:0] rptr_r;
  logic [fwd_fifo_cnt_width_lp-1:0] count_r;
  logic                             enq;
  logic                             deq;

  assign ready_and_o = (count_r != fwd_fifo_cnt_width_lp'(fwd_fifo_depth_lp));
  assign v_o         = (count_r != '0);
  assign data_o      = entries_r[rptr_r];

  assign enq = v_i & ready_and_o;
  assign deq = yumi_i & v_o;

  // storage
  always_ff @(posedge clk_i) begin
    if (enq) begin
      entries_r[wptr_r] <= data_i;
    end
  end

  // pointers and fill count
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end else begin
      if (enq) begin
        if (wptr_r == fwd_fifo_ptr_width_lp'(fwd_fifo_depth_lp - 1)) begin
          wptr_r <= '0;
        end else begin
          wptr_r <= wptr_r + 1'b1;
        end
      end
      if (deq) begin
        if (rptr_r == fwd_fifo_ptr_width_lp'(fwd_fifo_depth_lp - 1)) begin
          rptr_r <= '0;
        end else begin
          rptr_r <= rptr_r + 1'b1;
        end
      end
      // simultaneous enq and deq leaves the count alone
      case ({enq, deq})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/mem_scratchpad.sv */
////////////////////
// dword scratchpad executing uncached reads and writes
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mem_scratchpad (
  input  wire logic          clk_i,
  input  wire logic          reset_i,

  input  wire wbmem_pkg::mem_msg_s fwd_msg_i,
  input  wire logic          fwd_v_i,
  output logic               fwd_yumi_o,

  output wbmem_pkg::mem_msg_s rev_msg_o,
  output logic               rev_v_o
);

  import wbmem_pkg::*;

  localparam int num_dwords_lp = 2 ** sp_index_width_lp;

  logic [data_width_lp-1:0]     mem_r [num_dwords_lp];
  logic [sp_index_width_lp-1:0] clr_idx_r;
  logic                         clearing_r;
  logic [sp_index_width_lp-1:0] index;
  logic [data_width_lp-1:0]     old_data;
  logic [data_width_lp-1:0]     wr_merged;
  logic [3:0]                   byte_cnt;
  logic                         wr_en;
  mem_msg_s                     rev_msg_r;
  logic                         rev_v_r;

  // dword index sits just above the byte offset
  assign index    = fwd_msg_i.hdr.addr[byte_offset_width_lp +: sp_index_width_lp];
  assign old_data = mem_r[index];
  assign byte_cnt = 4'd1 << fwd_msg_i.hdr.size;

  // responder is always drained, so only the clear sweep blocks
  assign fwd_yumi_o = fwd_v_i & ~clearing_r;
  assign wr_en      = fwd_yumi_o & (fwd_msg_i.hdr.msg_type == uc_wr);

  // low size bytes replaced, rest kept
  always_comb begin
    wr_merged = old_data;
    for (int i = 0; i < sel_width_lp; i++) begin
      if (i < int'(byte_cnt)) begin
        wr_merged[8*i +: 8] = fwd_msg_i.data[8*i +: 8];
      end
    end
  end

  // clear sweep after reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      clearing_r <= 1'b1;
      clr_idx_r  <= '0;
    end else if (clearing_r) begin
      clr_idx_r <= clr_idx_r + 1'b1;
      if (clr_idx_r == '1) begin
        clearing_r <= 1'b0;
      end
    end
  end

  // single write port shared by sweep and commands
  always_ff @(posedge clk_i) begin
    if (clearing_r) begin
      mem_r[clr_idx_r] <= '0;
    end else if (wr_en) begin
      mem_r[index] <= wr_merged;
    end
  end

  // response echoes the header
  always_ff @(posedge clk_i) begin
    if (fwd_yumi_o) begin
      rev_msg_r.hdr  <= fwd_msg_i.hdr;
      rev_msg_r.data <= replicate_low(old_data, fwd_msg_i.hdr.size);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rev_v_r <= 1'b0;
    end else begin
      rev_v_r <= fwd_yumi_o;
    end
  end

  assign rev_msg_o = rev_msg_r;
  assign rev_v_o   = rev_v_r;

endmodule

`default_nettype wire

/* design/wbmem_top.sv */
////////////////////
// bridge, command FIFO and scratchpad
////////////////////
`timescale 1ns/1ps
`default_nettype none

module wbmem_top (
  input  wire logic                                  clk_i,
  input  wire logic                                  reset_i,

  input  wire logic [wbmem_pkg::wb_addr_width_lp-1:0] adr_i,
  input  wire logic [wbmem_pkg::data_width_lp-1:0]    dat_i,
  input  wire logic                                  cyc_i,
  input  wire logic                                  stb_i,
  input  wire logic [wbmem_pkg::sel_width_lp-1:0]     sel_i,
  input  wire logic                                  we_i,
  output logic [wbmem_pkg::data_width_lp-1:0]         dat_o,
  output logic                                       ack_o
);

  import wbmem_pkg::*;

  // bridge to FIFO
  mem_msg_s fwd_msg;
  logic     fwd_v;
  logic     fwd_ready_and;

  // FIFO to scratchpad
  mem_msg_s fifo_msg;
  logic     fifo_v;
  logic     fifo_yumi;

  // scratchpad to bridge
  mem_msg_s rev_msg;
  logic     rev_v;

  wb_client_bridge bridge_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .adr_i           (adr_i),
    .dat_i           (dat_i),
    .cyc_i           (cyc_i),
    .stb_i           (stb_i),
    .sel_i           (sel_i),
    .we_i            (we_i),
    .dat_o           (dat_o),
    .ack_o           (ack_o),
    .fwd_msg_o       (fwd_msg),
    .fwd_v_o         (fwd_v),
    .fwd_ready_and_i (fwd_ready_and),
    .rev_msg_i       (rev_msg),
    .rev_v_i         (rev_v)
  );

  mem_fwd_fifo fifo_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .data_i      (fwd_msg),
    .v_i         (fwd_v),
    .ready_and_o (fwd_ready_and),
    .data_o      (fifo_msg),
    .v_o         (fifo_v),
    .yumi_i      (fifo_yumi)
  );

  mem_scratchpad scratchpad_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .fwd_msg_i  (fifo_msg),
    .fwd_v_i    (fifo_v),
    .fwd_yumi_o (fifo_yumi),
    .rev_msg_o  (rev_msg),
    .rev_v_o    (rev_v)
  );

endmodule

`default_nettype wire

/* dv/wbmem_assertions.sv */
////////////////////
// bus and channel protocol assertions
////////////////////
`timescale 1ns/1ps
`default_nettype none

module wbmem_assertions (
  input wire logic                clk_i,
  input wire logic                reset_i,
  input wire logic                cyc_i,
  input wire logic                stb_i,
  input wire logic                ack_i,
  input wire logic                fwd_v_i,
  input wire logic                fwd_ready_and_i,
  input wire logic                fifo_v_i,
  input wire logic                fifo_yumi_i,
  input wire logic                rev_v_i,
  input wire wbmem_pkg::mem_msg_s rev_msg_i
);

  import wbmem_pkg::*;

  logic [1:0] fifo_count_r;
  logic       fwd_hs;
  logic       fifo_deq;
  logic       hs_d1_r;
  logic       hs_armed_r;
  logic       rd_resp;

  assign fwd_hs   = fwd_v_i & fwd_ready_and_i;
  assign fifo_deq = fifo_v_i & fifo_yumi_i;
  assign rd_resp  = rev_v_i & (rev_msg_i.hdr.msg_type == uc_rd);

  // own occupancy count and a flag for a handshake two or more cycles back
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fifo_count_r <= '0;
      hs_d1_r      <= 1'b0;
      hs_armed_r   <= 1'b0;
    end else begin
      fifo_count_r <= fifo_count_r + {1'b0, fwd_hs} - {1'b0, fifo_deq};
      hs_d1_r      <= fwd_hs;
      hs_armed_r   <= hs_armed_r | hs_d1_r;
    end
  end

  ack_in_request: assert property (@(posedge clk_i) disable iff (reset_i)
    ack_i |-> (cyc_i && stb_i))
    else $error("ack_o high outside a bus request");

  quiet_in_reset: assert property (@(posedge clk_i)
    reset_i |-> (!fwd_v_i && !ack_i))
    else $error("command valid or ack during reset");

  no_enq_when_full: assert property (@(posedge clk_i) disable iff (reset_i)
    fwd_hs |-> (fifo_count_r != 2'(fwd_fifo_depth_lp)))
    else $error("command accepted into a full FIFO");

  read_resp_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    rd_resp |-> hs_armed_r)
    else $error("read response without an earlier command handshake");

endmodule

bind wbmem_top wbmem_assertions assertions_i (
  .clk_i           (clk_i),
  .reset_i         (reset_i),
  .cyc_i           (cyc_i),
  .stb_i           (stb_i),
  .ack_i           (ack_o),
  .fwd_v_i         (fwd_v),
  .fwd_ready_and_i (fwd_ready_and),
  .fifo_v_i        (fifo_v),
  .fifo_yumi_i     (fifo_yumi),
  .rev_v_i         (rev_v),
  .rev_msg_i       (rev_msg)
);

`default_nettype wire

/* dv/wbmem_tb.sv */
////////////////////
// testbench with Wishbone master tasks and reference model
////////////////////
`timescale 1ns/1ps
`default_nettype none

module wbmem_tb;

  import wbmem_pkg::*;

  localparam int ack_timeout_lp   = 50;
  localparam int sweep_timeout_lp = 300;
  localparam int num_dwords_lp    = 2 ** sp_index_width_lp;

  logic                        clk_i;
  logic                        reset_i;
  logic [wb_addr_width_lp-1:0] adr_i;
  logic [data_width_lp-1:0]    dat_i;
  logic                        cyc_i;
  logic                        stb_i;
  logic [sel_width_lp-1:0]     sel_i;
  logic                        we_i;
  logic [data_width_lp-1:0]    dat_o;
  logic                        ack_o;

  // expected contents, one dword per scratchpad entry
  logic [data_width_lp-1:0] ref_mem [num_dwords_lp];
  int seed = 32'h56b92268;
  int errors;
  int errors_at_start;
  int tests_passed;
  int tests_failed;

  wbmem_top dut_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .adr_i   (adr_i),
    .dat_i   (dat_i),
    .cyc_i   (cyc_i),
    .stb_i   (stb_i),
    .sel_i   (sel_i),
    .we_i    (we_i),
    .dat_o   (dat_o),
    .ack_o   (ack_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // bytes covered by a select pattern
  function automatic int sel_bytes(input logic [sel_width_lp-1:0] sel);
    case (sel)
      8'h01:   return 1;
      8'h03:   return 2;
      8'h0F:   return 4;
      default: return 8;
    endcase
  endfunction

  function automatic logic [data_width_lp-1:0] expected_read(
    input logic [wb_addr_width_lp-1:0] adr,
    input logic [sel_width_lp-1:0]     sel
  );
    logic [data_width_lp-1:0] word;
    logic [data_width_lp-1:0] result;
    int n;
    word = ref_mem[adr[sp_index_width_lp-1:0]];
    n = sel_bytes(sel);
    // low n bytes repeat across the bus
    for (int i = 0; i < sel_width_lp; i++) begin
      result[8*i +: 8] = word[8*(i % n) +: 8];
    end
    return result;
  endfunction

  task automatic store_expected(
    input logic [wb_addr_width_lp-1:0] adr,
    input logic [data_width_lp-1:0]    dat,
    input logic [sel_width_lp-1:0]     sel
  );
    int n;
    n = sel_bytes(sel);
    for (int i = 0; i < n; i++) begin
      ref_mem[adr[sp_index_width_lp-1:0]][8*i +: 8] = dat[8*i +: 8];
    end
  endtask

  // ack_o is combinational, so look at it mid cycle
  task automatic wait_ack(output logic ok);
    int cycles;
    cycles = 0;
    ok = 1'b0;
    while (!ok && cycles < ack_timeout_lp) begin
      @(negedge clk_i);
      if (ack_o) begin
        ok = 1'b1;
      end else begin
        cycles++;
      end
    end
  endtask

  task automatic wb_write(
    input logic [wb_addr_width_lp-1:0] adr,
    input logic [data_width_lp-1:0]    dat,
    input logic [sel_width_lp-1:0]     sel
  );
    logic ok;
    adr_i = adr;
    dat_i = dat;
    sel_i = sel;
    we_i  = 1'b1;
    cyc_i = 1'b1;
    stb_i = 1'b1;
    wait_ack(ok);
    @(posedge clk_i);
    #1;
    cyc_i = 1'b0;
    stb_i = 1'b0;
    if (ok) begin
      store_expected(adr, dat, sel);
    end else begin
      $display("timeout: write to word address %h was never acknowledged", adr);
      errors++;
    end
  endtask

  task automatic wb_read(
    input logic [wb_addr_width_lp-1:0] adr,
    input logic [sel_width_lp-1:0]     sel
  );
    logic                     ok;
    logic [data_width_lp-1:0] expected;
    logic [data_width_lp-1:0] actual;
    adr_i = adr;
    dat_i = '0;
    sel_i = sel;
    we_i  = 1'b0;
    cyc_i = 1'b1;
    stb_i = 1'b1;
    wait_ack(ok);
    actual = dat_o;
    @(posedge clk_i);
    #1;
    cyc_i = 1'b0;
    stb_i = 1'b0;
    if (!ok) begin
      $display("timeout: read of word address %h was never acknowledged", adr);
      errors++;
    end else begin
      expected = expected_read(adr, sel);
      assert (actual == expected) else begin
        $display("FAIL %0t read adr %h sel %h expected %h actual %h",
                 $time, adr, sel, expected, actual);
        errors++;
      end
    end
  endtask

  task automatic report_test(input string name);
    if (errors == errors_at_start) begin
      tests_passed++;
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  initial begin
    int                          wait_cycles;
    logic [wb_addr_width_lp-1:0] adr;
    logic [wb_addr_width_lp-1:0] rand_adr [8];
    logic [sel_width_lp-1:0]     sel;
    errors          = 0;
    errors_at_start = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    // a write request held through reset must be ignored
    reset_i = 1'b1;
    adr_i   = '0;
    dat_i   = '0;
    cyc_i   = 1'b1;
    stb_i   = 1'b1;
    sel_i   = 8'hFF;
    we_i    = 1'b1;
    for (int i = 0; i < num_dwords_lp; i++) begin
      ref_mem[i] = '0;
    end
    repeat (5) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    cyc_i   = 1'b0;
    stb_i   = 1'b0;
    we_i    = 1'b0;

    // scratchpad zeroes itself before taking commands
    wait_cycles = 0;
    while (dut_i.scratchpad_i.clearing_r && wait_cycles < sweep_timeout_lp) begin
      @(posedge clk_i);
      #1;
      wait_cycles++;
    end
    if (wait_cycles >= sweep_timeout_lp) begin
      $display("timeout: scratchpad clear sweep did not finish");
      errors++;
    end

    for (int i = 0; i < 4; i++) begin
      wb_read(17'(i * 37), 8'hFF);
    end
    for (int i = 0; i < 8; i++) begin
      rand_adr[i] = 17'($random(seed));
      wb_write(rand_adr[i], {$random(seed), $random(seed)}, 8'hFF);
    end
    for (int i = 0; i < 8; i++) begin
      wb_read(rand_adr[i], 8'hFF);
    end
    report_test("reset_and_full_dwords");

    adr = 17'h00123;
    wb_write(adr, 64'h0123_4567_89AB_CDEF, 8'hFF);
    wb_write(adr, 64'hFFFF_FFFF_FFFF_FF11, 8'h01);
    wb_read(adr, 8'hFF);
    wb_write(adr, 64'hFFFF_FFFF_FFFF_2233, 8'h03);
    wb_read(adr, 8'hFF);
    wb_write(adr, 64'hFFFF_FFFF_4455_6677, 8'h0F);
    wb_read(adr, 8'hFF);
    report_test("narrow_writes");

    adr = 17'h00A07;
    wb_write(adr, 64'hFEDC_BA98_7654_3210, 8'hFF);
    wb_read(adr, 8'h01);
    wb_read(adr, 8'h03);
    wb_read(adr, 8'h0F);
    report_test("narrow_reads");

    adr = 17'h01F3C;
    wb_write(adr, 64'h1122_3344_5566_7788, 8'hF0);
    wb_read(adr, 8'hFF);
    wb_read(adr, 8'hF0);
    wb_read(adr, 8'h3C);
    report_test("odd_select");

    adr = 17'h00042;
    wb_write(adr, 64'hAAAA_0000_AAAA_0000, 8'hFF);
    wb_write(adr + 17'd256, 64'h5555_1111_5555_1111, 8'hFF);
    wb_read(adr, 8'hFF);
    wb_read(adr + 17'd256, 8'hFF);
    report_test("index_alias");

    // small address range so reads mostly hit written data
    for (int i = 0; i < 200; i++) begin
      adr = {11'd0, 6'($random(seed))};
      case (2'($random(seed)))
        2'd0:    sel = 8'h01;
        2'd1:    sel = 8'h03;
        2'd2:    sel = 8'h0F;
        default: sel = 8'($random(seed));
      endcase
      if (1'($random(seed))) begin
        wb_write(adr, {$random(seed), $random(seed)}, sel);
      end else begin
        wb_read(adr, sel);
      end
    end
    report_test("random_traffic");

    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (tests_failed == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* wbmem.f */
design/wbmem_pkg.sv
design/wb_client_bridge.sv
design/mem_fwd_fifo.sv
design/mem_scratchpad.sv
design/wbmem_top.sv
dv/wbmem_assertions.sv
dv/wbmem_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= wbmem_tb
FILELIST  ?= wbmem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= >>> FAIL
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
